// ==== source/risc_pkg.sv ====
package risc_pkg;

    localparam int INSTR_W = 12;
    localparam int DATA_W  = 8;
    localparam int FILE_AW = 5;

    // Special file addresses, 9 and up are general registers
    localparam logic [FILE_AW-1:0] STATUS_ADDR = 5'd3;
    localparam logic [FILE_AW-1:0] IN0_ADDR    = 5'd5;
    localparam logic [FILE_AW-1:0] IN1_ADDR    = 5'd6;
    localparam logic [FILE_AW-1:0] OUT0_ADDR   = 5'd7;
    localparam logic [FILE_AW-1:0] OUT1_ADDR   = 5'd8;

    localparam int Z_BIT = 2;
    localparam int C_BIT = 0;

    localparam logic [9:0] CTRL_ADDR = 10'h200;  // Run register, program words below

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_COM, ALU_INC, ALU_DEC, ALU_ROR, ALU_ROL, ALU_SWAP,
        ALU_PASS_A, ALU_PASS_B, ALU_ZERO, ALU_BSF, ALU_BCF
    } alu_op_e;

    typedef enum logic [1:0] {PC_NEXT, PC_GOTO, PC_RET} pc_ctl_e;

    typedef enum logic [1:0] {STK_NOP, STK_PUSH, STK_POP} stk_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_ON_ZERO, BR_ON_NONZERO} branch_e;

    typedef enum logic {A_W, A_BIT_MASK} a_sel_e;

    typedef enum logic {B_FILE, B_LITERAL} b_sel_e;

endpackage

// ==== source/host_ctrl.sv ====
`timescale 1ns/10ps
module host_ctrl #(
    parameter int PC_W = 9
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [9:0]                    wb_adr,
    input  logic [risc_pkg::INSTR_W-1:0]  wb_dat_w,
    output logic [risc_pkg::INSTR_W-1:0]  wb_dat_r,
    output logic                          wb_ack,
    output logic                          prog_we,
    output logic [PC_W-1:0]               prog_addr,
    output logic [risc_pkg::INSTR_W-1:0]  prog_data,
    output logic                          core_rst
);
    import risc_pkg::*;

    logic req;       // New access, acked on the next edge
    logic done;      // Acked, waiting for strobe to drop
    logic run;
    logic ctrl_sel;

    assign req       = wb_cyc && wb_stb && !wb_ack && !done;
    assign ctrl_sel  = (wb_adr == CTRL_ADDR);
    assign prog_we   = req && wb_we && (wb_adr < CTRL_ADDR);
    assign prog_addr = wb_adr[PC_W-1:0];
    assign prog_data = wb_dat_w;
    assign wb_dat_r  = ctrl_sel ? INSTR_W'(run) : '0;
    assign core_rst  = rst || !run;  // Core held while stopped

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack <= 1'b0;
            done   <= 1'b0;
            run    <= 1'b0;
        end
        else
        begin
            wb_ack <= req;
            done   <= wb_cyc && wb_stb && (wb_ack || done);
            if (req && wb_we && ctrl_sel)
                run <= wb_dat_w[0];
        end
    end

endmodule

// ==== source/program_ram.sv ====
`timescale 1ns/10ps
module program_ram #(
    parameter int PC_W = 9
) (
    input  logic                          clk,
    input  logic                          prog_we,
    input  logic [PC_W-1:0]               prog_addr,
    input  logic [risc_pkg::INSTR_W-1:0]  prog_data,
    input  logic [PC_W-1:0]               fetch_addr,
    output logic [risc_pkg::INSTR_W-1:0]  instr
);
    import risc_pkg::*;

    logic [INSTR_W-1:0] mem [2**PC_W];

    always_ff @(posedge clk)
    begin
        if (prog_we)
            mem[prog_addr] <= prog_data;
        instr <= mem[fetch_addr];  // Fetch at the next PC
    end

endmodule

// ==== source/pc_stack.sv ====
`timescale 1ns/10ps
module pc_stack #(
    parameter int PC_W        = 9,
    parameter int STACK_DEPTH = 2
) (
    input  logic               clk,
    input  logic               core_rst,
    input  risc_pkg::pc_ctl_e  pc_ctl,
    input  risc_pkg::stk_op_e  stk_op,
    input  logic [PC_W-1:0]    jump_target,
    input  logic               skip,
    output logic [PC_W-1:0]    fetch_addr
);
    import risc_pkg::*;

    logic [PC_W-1:0] pc;        // Address of the word in decode
    logic [PC_W-1:0] pc_inc;
    logic [PC_W-1:0] stack [STACK_DEPTH];

    assign pc_inc = pc + 1'b1;

    always_comb
    begin
        if (core_rst)
            fetch_addr = '0;
        else if (skip)
            fetch_addr = pc_inc;  // Squashed word has no PC effect
        else
        begin
            case (pc_ctl)
                PC_GOTO: fetch_addr = jump_target;
                PC_RET:  fetch_addr = stack[0];
                default: fetch_addr = pc_inc;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (core_rst)
            pc <= '0;
        else
            pc <= fetch_addr;
    end

    // Shift stack, top at entry 0
    always_ff @(posedge clk)
    begin
        if (!core_rst && !skip)
        begin
            case (stk_op)
                STK_PUSH:
                begin
                    stack[0] <= pc_inc;
                    for (int i = 1; i < STACK_DEPTH; i++)
                        stack[i] <= stack[i-1];
                end
                STK_POP:
                begin
                    for (int i = 0; i < STACK_DEPTH - 1; i++)
                        stack[i] <= stack[i+1];
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

// ==== source/instr_decode.sv ====
`timescale 1ns/10ps
module instr_decode #(
    parameter int PC_W = 9
) (
    input  logic                          clk,
    input  logic                          core_rst,
    input  logic [risc_pkg::INSTR_W-1:0]  instr,
    input  logic                          zero,
    output risc_pkg::pc_ctl_e             pc_ctl,
    output risc_pkg::stk_op_e             stk_op,
    output logic [PC_W-1:0]               jump_target,
    output logic                          skip,
    output risc_pkg::alu_op_e             alu_op,
    output risc_pkg::a_sel_e              a_sel,
    output risc_pkg::b_sel_e              b_sel,
    output logic [2:0]                    bit_sel,
    output logic [risc_pkg::DATA_W-1:0]   literal,
    output logic                          w_we,
    output logic [risc_pkg::FILE_AW-1:0]  file_addr,
    output logic                          file_we,
    output logic                          z_we,
    output logic                          c_we
);
    import risc_pkg::*;

    alu_op_e     alu_op_d;
    a_sel_e      a_sel_d;
    b_sel_e      b_sel_d;
    branch_e     branch_d;
    branch_e     branch_q;
    logic        w_we_d;
    logic        file_we_d;
    logic        z_we_d;
    logic        c_we_d;
    logic [3:0]  byte_op;
    logic        dest_f;      // 1 writes back to the file
    logic [8:0]  target;

    assign byte_op     = instr[9:6];
    assign dest_f      = instr[5];
    assign jump_target = PC_W'(target);

    always_comb
    begin
        pc_ctl    = PC_NEXT;
        stk_op    = STK_NOP;
        target    = instr[8:0];
        alu_op_d  = ALU_NOP;
        a_sel_d   = A_W;
        b_sel_d   = B_FILE;
        branch_d  = BR_NONE;
        w_we_d    = 1'b0;
        file_we_d = 1'b0;
        z_we_d    = 1'b0;
        c_we_d    = 1'b0;
        case (instr[11:10])
            2'b00:
            begin
                // Byte file ops, opcode in bits 9:6
                case (byte_op)
                    4'b0000: alu_op_d = dest_f ? ALU_PASS_A : ALU_NOP;  // MOVWF
                    4'b0001: alu_op_d = ALU_ZERO;                       // CLRW, CLRF
                    4'b0010: alu_op_d = ALU_SUB;
                    4'b0011: alu_op_d = ALU_DEC;
                    4'b0100: alu_op_d = ALU_OR;
                    4'b0101: alu_op_d = ALU_AND;
                    4'b0110: alu_op_d = ALU_XOR;
                    4'b0111: alu_op_d = ALU_ADD;
                    4'b1000: alu_op_d = ALU_PASS_B;                     // MOVF
                    4'b1001: alu_op_d = ALU_COM;
                    4'b1010: alu_op_d = ALU_INC;
                    4'b1011: alu_op_d = ALU_DEC;                        // DECFSZ
                    4'b1100: alu_op_d = ALU_ROR;
                    4'b1101: alu_op_d = ALU_ROL;
                    4'b1110: alu_op_d = ALU_SWAP;
                    default: alu_op_d = ALU_INC;                        // INCFSZ
                endcase
                w_we_d    = !dest_f && (byte_op != 4'b0000);
                file_we_d = dest_f;
                z_we_d    = (byte_op >= 4'b0001) && (byte_op <= 4'b1010);
                c_we_d    = (byte_op == 4'b0010) || (byte_op == 4'b0111) ||
                            (byte_op == 4'b1100) || (byte_op == 4'b1101);
                if (byte_op == 4'b1011 || byte_op == 4'b1111)
                    branch_d = BR_ON_ZERO;
            end
            2'b01:
            begin
                // BCF, BSF, BTFSC, BTFSS
                a_sel_d   = A_BIT_MASK;
                alu_op_d  = instr[9] ? ALU_AND : (instr[8] ? ALU_BSF : ALU_BCF);
                file_we_d = !instr[9];
                if (instr[9])
                    branch_d = instr[8] ? BR_ON_NONZERO : BR_ON_ZERO;
            end
            2'b10:
            begin
                case (instr[9:8])
                    2'b00:
                    begin
                        pc_ctl   = PC_RET;  // RETLW
                        stk_op   = STK_POP;
                        alu_op_d = ALU_PASS_B;
                        b_sel_d  = B_LITERAL;
                        w_we_d   = 1'b1;
                    end
                    2'b01:
                    begin
                        pc_ctl = PC_GOTO;   // CALL reaches the low 256 words
                        stk_op = STK_PUSH;
                        target = {1'b0, instr[7:0]};
                    end
                    default: pc_ctl = PC_GOTO;
                endcase
            end
            default:
            begin
                // MOVLW, IORLW, ANDLW, XORLW
                b_sel_d = B_LITERAL;
                w_we_d  = 1'b1;
                z_we_d  = (instr[9:8] != 2'b00);
                case (instr[9:8])
                    2'b00:   alu_op_d = ALU_PASS_B;
                    2'b01:   alu_op_d = ALU_OR;
                    2'b10:   alu_op_d = ALU_AND;
                    default: alu_op_d = ALU_XOR;
                endcase
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (core_rst || skip)
        begin
            alu_op   <= ALU_NOP;
            branch_q <= BR_NONE;
            w_we     <= 1'b0;
            file_we  <= 1'b0;
            z_we     <= 1'b0;
            c_we     <= 1'b0;
        end
        else
        begin
            alu_op   <= alu_op_d;
            branch_q <= branch_d;
            w_we     <= w_we_d;
            file_we  <= file_we_d;
            z_we     <= z_we_d;
            c_we     <= c_we_d;
        end
        a_sel     <= a_sel_d;
        b_sel     <= b_sel_d;
        bit_sel   <= instr[7:5];
        literal   <= instr[7:0];
        file_addr <= instr[4:0];
    end

    // Skip resolved on the execute-stage result
    always_comb
    begin
        case (branch_q)
            BR_ON_ZERO:    skip = zero;
            BR_ON_NONZERO: skip = !zero;
            default:       skip = 1'b0;
        endcase
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/10ps
module alu (
    input  logic                         clk,
    input  logic                         core_rst,
    input  risc_pkg::alu_op_e            alu_op,
    input  risc_pkg::a_sel_e             a_sel,
    input  risc_pkg::b_sel_e             b_sel,
    input  logic [2:0]                   bit_sel,
    input  logic [risc_pkg::DATA_W-1:0]  literal,
    input  logic [risc_pkg::DATA_W-1:0]  file_data,
    input  logic                         carry_in,
    input  logic                         w_we,
    output logic [risc_pkg::DATA_W-1:0]  result,
    output logic                         carry_out,
    output logic                         zero
);
    import risc_pkg::*;

    logic [DATA_W-1:0] w_reg;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;

    assign op_a = (a_sel == A_W) ? w_reg : (DATA_W'(1) << bit_sel);
    assign op_b = (b_sel == B_FILE) ? file_data : literal;
    assign zero = (result == '0);

    always_comb
    begin
        carry_out = carry_in;
        case (alu_op)
            ALU_ADD:    {carry_out, result} = {1'b0, op_b} + {1'b0, op_a};
            ALU_SUB:    {carry_out, result} = {1'b1, op_b} - {1'b0, op_a};  // C is not-borrow
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_COM:    result = ~op_b;
            ALU_INC:    result = op_b + 1'b1;
            ALU_DEC:    result = op_b - 1'b1;
            ALU_ROR:    {carry_out, result} = {op_b[0], carry_in, op_b[DATA_W-1:1]};
            ALU_ROL:    {carry_out, result} = {op_b, carry_in};
            ALU_SWAP:   result = {op_b[3:0], op_b[7:4]};
            ALU_PASS_A: result = op_a;
            ALU_PASS_B: result = op_b;
            ALU_BSF:    result = op_a | op_b;
            ALU_BCF:    result = ~op_a & op_b;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (core_rst)
            w_reg <= '0;
        else if (w_we)
            w_reg <= result;
    end

endmodule

// ==== source/file_regs.sv ====
`timescale 1ns/10ps
module file_regs (
    input  logic                          clk,
    input  logic                          core_rst,
    input  logic [risc_pkg::FILE_AW-1:0]  file_addr,
    input  logic                          file_we,
    input  logic                          z_we,
    input  logic                          c_we,
    input  logic [risc_pkg::DATA_W-1:0]   result,
    input  logic                          carry_out,
    input  logic                          zero,
    input  logic [risc_pkg::DATA_W-1:0]   in0,
    input  logic [risc_pkg::DATA_W-1:0]   in1,
    output logic [risc_pkg::DATA_W-1:0]   file_data,
    output logic                          carry_in,
    output logic [risc_pkg::DATA_W-1:0]   out0,
    output logic [risc_pkg::DATA_W-1:0]   out1
);
    import risc_pkg::*;

    localparam int GPR_BASE = OUT1_ADDR + 1;

    logic [DATA_W-1:0] gpr [GPR_BASE:2**FILE_AW-1];
    logic [DATA_W-1:0] status;
    logic              is_gpr;

    assign is_gpr   = (file_addr >= GPR_BASE);
    assign carry_in = status[C_BIT];

    // Read on the execute-stage address
    always_comb
    begin
        case (file_addr)
            STATUS_ADDR: file_data = status;
            IN0_ADDR:    file_data = in0;
            IN1_ADDR:    file_data = in1;
            OUT0_ADDR:   file_data = out0;
            OUT1_ADDR:   file_data = out1;
            default:     file_data = is_gpr ? gpr[file_addr] : '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (file_we && is_gpr)
            gpr[file_addr] <= result;
    end

    always_ff @(posedge clk)
    begin
        if (core_rst)
        begin
            status <= '0;
            out0   <= '0;
            out1   <= '0;
        end
        else
        begin
            if (file_we && file_addr == STATUS_ADDR)
                status <= result;  // Direct write beats flag update
            else
            begin
                if (z_we)
                    status[Z_BIT] <= zero;
                if (c_we)
                    status[C_BIT] <= carry_out;
            end
            if (file_we && file_addr == OUT0_ADDR)
                out0 <= result;
            if (file_we && file_addr == OUT1_ADDR)
                out1 <= result;
        end
    end

endmodule

// ==== source/risc_top.sv ====
`timescale 1ns/10ps
module risc_top #(
    parameter int PC_W        = 9,
    parameter int STACK_DEPTH = 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [9:0]                    wb_adr,
    input  logic [risc_pkg::INSTR_W-1:0]  wb_dat_w,
    output logic [risc_pkg::INSTR_W-1:0]  wb_dat_r,
    output logic                          wb_ack,
    input  logic [risc_pkg::DATA_W-1:0]   in0,
    input  logic [risc_pkg::DATA_W-1:0]   in1,
    output logic [risc_pkg::DATA_W-1:0]   out0,
    output logic [risc_pkg::DATA_W-1:0]   out1
);
    import risc_pkg::*;

    // Host side
    logic                 prog_we;
    logic [PC_W-1:0]      prog_addr;
    logic [INSTR_W-1:0]   prog_data;
    logic                 core_rst;

    // Fetch and decode
    logic [PC_W-1:0]      fetch_addr;
    logic [INSTR_W-1:0]   instr;
    pc_ctl_e              pc_ctl;
    stk_op_e              stk_op;
    logic [PC_W-1:0]      jump_target;
    logic                 skip;

    // Execute stage
    alu_op_e              alu_op;
    a_sel_e               a_sel;
    b_sel_e               b_sel;
    logic [2:0]           bit_sel;
    logic [DATA_W-1:0]    literal;
    logic                 w_we;
    logic [FILE_AW-1:0]   file_addr;
    logic                 file_we;
    logic                 z_we;
    logic                 c_we;
    logic [DATA_W-1:0]    file_data;
    logic [DATA_W-1:0]    result;
    logic                 carry_in;
    logic                 carry_out;
    logic                 zero;

    host_ctrl #(.PC_W(PC_W)) i_host_ctrl (.*);

    program_ram #(.PC_W(PC_W)) i_program_ram (.*);

    pc_stack #(
        .PC_W        (PC_W),
        .STACK_DEPTH (STACK_DEPTH)
    ) i_pc_stack (.*);

    instr_decode #(.PC_W(PC_W)) i_instr_decode (.*);

    alu i_alu (.*);

    file_regs i_file_regs (.*);

endmodule

// ==== dv/risc_top_sva.sv ====
`timescale 1ns/10ps
module risc_top_sva (
    input logic                         clk,
    input logic                         rst,
    input logic                         wb_cyc,
    input logic                         wb_stb,
    input logic                         wb_ack,
    input logic                         core_rst,
    input logic [risc_pkg::DATA_W-1:0]  out0,
    input logic [risc_pkg::DATA_W-1:0]  out1
);

    int failures = 0;  // Failed assertions so far

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else
        begin
            $error("wb_ack high outside an active bus cycle");
            failures++;
        end

    // Single-cycle acknowledge
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else
        begin
            $error("wb_ack high for two cycles in a row");
            failures++;
        end

    ports_cleared: assert property (@(posedge clk)
        core_rst |=> (out0 == '0 && out1 == '0))
        else
        begin
            $error("output ports not cleared after core reset");
            failures++;
        end

endmodule

bind risc_top risc_top_sva i_risc_top_sva (.*);

// ==== dv/tb_risc_top.sv ====
`timescale 1ns/10ps
module tb_risc_top;
    import risc_pkg::*;

    localparam int MAX_CYCLES = 4000;  // All tests plus margin

    // Byte op codes, bits 9:6
    localparam logic [3:0] OP_MOVWF  = 4'h0;
    localparam logic [3:0] OP_CLR    = 4'h1;
    localparam logic [3:0] OP_SUBWF  = 4'h2;
    localparam logic [3:0] OP_ADDWF  = 4'h7;
    localparam logic [3:0] OP_MOVF   = 4'h8;
    localparam logic [3:0] OP_COMF   = 4'h9;
    localparam logic [3:0] OP_INCF   = 4'hA;
    localparam logic [3:0] OP_DECFSZ = 4'hB;
    localparam logic [3:0] OP_RRF    = 4'hC;
    localparam logic [3:0] OP_RLF    = 4'hD;
    localparam logic [4:0] R_A       = 5'd9;   // General registers
    localparam logic [4:0] R_B       = 5'd10;

    logic                clk;
    logic                rst;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [9:0]          wb_adr;
    logic [INSTR_W-1:0]  wb_dat_w;
    logic [INSTR_W-1:0]  wb_dat_r;
    logic                wb_ack;
    logic [DATA_W-1:0]   in0;
    logic [DATA_W-1:0]   in1;
    logic [DATA_W-1:0]   out0;
    logic [DATA_W-1:0]   out1;

    integer              seed;
    int                  errors;
    int                  checks;
    int                  sva_failures;
    int                  cycle_count = 0;
    logic [INSTR_W-1:0]  prog [$];

    risc_top i_risc_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // Instruction assembly
    function automatic logic [11:0] byte_instr(input logic [3:0] op, input logic to_file,
                                               input logic [4:0] f);
        return {2'b00, op, to_file, f};
    endfunction

    // Kind 0 BCF, 1 BSF, 2 BTFSC, 3 BTFSS
    function automatic logic [11:0] bit_instr(input logic [1:0] kind, input logic [2:0] b,
                                              input logic [4:0] f);
        return {2'b01, kind, b, f};
    endfunction

    // Kind 0 MOVLW, 1 IORLW, 2 ANDLW, 3 XORLW
    function automatic logic [11:0] lit_instr(input logic [1:0] kind, input logic [7:0] k);
        return {2'b11, kind, k};
    endfunction

    function automatic logic [11:0] goto_to(input logic [8:0] target);
        return {3'b101, target};
    endfunction

    function automatic logic [11:0] call_to(input logic [7:0] target);
        return {4'b1001, target};
    endfunction

    function automatic logic [11:0] retlw(input logic [7:0] k);
        return {4'b1000, k};
    endfunction

    task automatic add_halt();
        prog.push_back(goto_to(9'(prog.size())));  // Jump to itself
    endtask

    task automatic compare(input string what, input logic [11:0] expected,
                           input logic [11:0] actual);
        checks++;
        if (actual !== expected)
        begin
            $display("ERROR at %0d ns: %s expected %h, got %h", $time, what, expected, actual);
            errors++;
        end
    endtask

    task automatic bus_access(input logic we, input logic [9:0] adr,
                              input logic [11:0] wdata, output logic [11:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(posedge clk);
        #1;
        while (!wb_ack && waited < 8)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        checks++;
        if (!wb_ack)
        begin
            $display("Bus access at address %h was never acknowledged", adr);
            errors++;
        end
        rdata = wb_dat_r;
        @(posedge clk);  // Ack seen on this edge
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [9:0] adr, input logic [11:0] data);
        logic [11:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [9:0] adr, output logic [11:0] data);
        bus_access(1'b0, adr, 12'h000, data);
    endtask

    task automatic load_program();
        wb_write(CTRL_ADDR, 12'h000);
        foreach (prog[i])
            wb_write(10'(i), prog[i]);
        prog.delete();
    endtask

    // One instruction per cycle, so a fixed wait covers the program
    task automatic run_for(input int cycles);
        wb_write(CTRL_ADDR, 12'h001);
        repeat (cycles + 6) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int e0, input int c0);
        $display("%-14s %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    task automatic test_control_reg();
        int          e0;
        int          c0;
        logic [11:0] data;
        e0 = errors;
        c0 = checks;
        prog.push_back(goto_to(9'd0));
        load_program();
        wb_write(CTRL_ADDR, 12'h001);
        wb_read(CTRL_ADDR, data);
        compare("run readback", 12'h001, data);
        wb_read(10'h005, data);
        compare("program word read", 12'h000, data);
        wb_write(CTRL_ADDR, 12'h000);
        wb_read(CTRL_ADDR, data);
        compare("run cleared", 12'h000, data);
        report_test("control_reg", e0, c0);
    endtask

    task automatic test_logic();
        int         e0;
        int         c0;
        logic [7:0] a;
        logic [7:0] k1;
        logic [7:0] k2;
        logic [7:0] k3;
        logic [7:0] k4;
        logic [7:0] expected;
        e0 = errors;
        c0 = checks;
        a  = $random(seed);
        k1 = $random(seed);
        k2 = $random(seed);
        k3 = $random(seed);
        k4 = $random(seed);
        in0 = a;
        prog.push_back(byte_instr(OP_MOVF, 1'b0, IN0_ADDR));
        prog.push_back(lit_instr(2'd1, k1));
        prog.push_back(lit_instr(2'd2, k2));
        prog.push_back(lit_instr(2'd3, k3));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, R_A));
        prog.push_back(byte_instr(OP_COMF, 1'b0, R_A));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT0_ADDR));
        prog.push_back(lit_instr(2'd0, k4));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT1_ADDR));
        add_halt();
        load_program();
        run_for(10);
        expected = ~(((a | k1) & k2) ^ k3);
        compare("logic chain on out0", expected, out0);
        compare("MOVLW on out1", k4, out1);
        report_test("logic", e0, c0);
    endtask

    // Result of f op W in a general register, then STATUS
    task automatic arith_case(input logic [3:0] op, input logic [7:0] a, input logic [7:0] b);
        logic [7:0] res;
        logic [7:0] status;
        in0 = a;
        in1 = b;
        prog.push_back(byte_instr(OP_MOVF, 1'b0, IN1_ADDR));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, R_A));
        prog.push_back(byte_instr(OP_MOVF, 1'b0, IN0_ADDR));
        prog.push_back(byte_instr(op, 1'b1, R_A));
        prog.push_back(byte_instr(OP_MOVF, 1'b0, STATUS_ADDR));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT1_ADDR));
        prog.push_back(byte_instr(OP_MOVF, 1'b0, R_A));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT0_ADDR));
        add_halt();
        load_program();
        run_for(9);
        status = 8'h00;
        if (op == OP_ADDWF)
        begin
            res = a + b;
            status[C_BIT] = (int'(a) + int'(b)) > 255;  // Carry out
        end
        else
        begin
            res = b - a;
            status[C_BIT] = (b >= a);  // No borrow
        end
        status[Z_BIT] = (res == 8'h00);
        compare("arithmetic result", res, out0);
        compare("status flags", status, out1);
    endtask

    task automatic rotate_case(input logic [7:0] a, input logic [7:0] b);
        logic carry;
        in0 = a;
        in1 = b;
        prog.push_back(byte_instr(OP_MOVF, 1'b0, IN0_ADDR));
        prog.push_back(byte_instr(OP_ADDWF, 1'b0, IN1_ADDR));
        prog.push_back(byte_instr(OP_RRF, 1'b0, IN0_ADDR));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT0_ADDR));
        prog.push_back(byte_instr(OP_RLF, 1'b0, IN1_ADDR));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT1_ADDR));
        add_halt();
        load_program();
        run_for(7);
        carry = (int'(a) + int'(b)) > 255;
        compare("RRF through carry", {carry, a[7:1]}, out0);
        compare("RLF through carry", {b[6:0], a[0]}, out1);
    endtask

    task automatic test_arith();
        int         e0;
        int         c0;
        logic [7:0] a;
        e0 = errors;
        c0 = checks;
        arith_case(OP_ADDWF, $random(seed), $random(seed));
        arith_case(OP_ADDWF, 8'hF0 | $random(seed), 8'h80 | $random(seed));
        arith_case(OP_SUBWF, $random(seed), $random(seed));
        a = $random(seed);
        arith_case(OP_SUBWF, a, a);  // Zero difference
        rotate_case($random(seed), $random(seed));
        report_test("arith", e0, c0);
    endtask

    task automatic test_skips();
        int         e0;
        int         c0;
        logic [7:0] n;
        logic [7:0] sel;
        logic [7:0] expected;
        e0 = errors;
        c0 = checks;
        n   = ($random(seed) & 8'h1f) + 1;
        sel = $random(seed);
        in0 = n;
        in1 = sel;
        prog.push_back(byte_instr(OP_MOVF, 1'b0, IN0_ADDR));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, R_A));
        prog.push_back(byte_instr(OP_CLR, 1'b1, R_B));
        prog.push_back(byte_instr(OP_INCF, 1'b1, R_B));  // Loop body at 3
        prog.push_back(byte_instr(OP_DECFSZ, 1'b1, R_A));
        prog.push_back(goto_to(9'd3));
        prog.push_back(byte_instr(OP_MOVF, 1'b0, R_B));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT0_ADDR));
        prog.push_back(bit_instr(2'd2, 3'd3, IN1_ADDR));
        prog.push_back(lit_instr(2'd0, 8'hB2));         // Bit 3 set
        prog.push_back(bit_instr(2'd3, 3'd3, IN1_ADDR));
        prog.push_back(lit_instr(2'd0, 8'hC3));         // Bit 3 clear
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT1_ADDR));
        add_halt();
        load_program();
        repeat (2)
        begin
            run_for(3 * int'(n) + 16);
            compare("DECFSZ loop count", n, out0);
            expected = sel[3] ? 8'hB2 : 8'hC3;
            compare("bit test select", expected, out1);
            wb_write(CTRL_ADDR, 12'h000);
            sel = ~sel;
            in1 = sel;
        end
        report_test("skips", e0, c0);
    endtask

    task automatic test_calls();
        int         e0;
        int         c0;
        logic [7:0] k1;
        logic [7:0] k2;
        e0 = errors;
        c0 = checks;
        k1 = $random(seed);
        k2 = $random(seed);
        prog.push_back(call_to(8'd3));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT1_ADDR));
        prog.push_back(goto_to(9'd2));
        prog.push_back(call_to(8'd6));  // Nested call
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT0_ADDR));
        prog.push_back(retlw(k1));
        prog.push_back(retlw(k2));
        load_program();
        run_for(8);
        compare("inner RETLW on out0", k2, out0);
        compare("outer RETLW on out1", k1, out1);
        report_test("calls", e0, c0);
    endtask

    task automatic test_bits_restart();
        int         e0;
        int         c0;
        logic [7:0] k;
        logic [7:0] a;
        logic [2:0] b_set;
        logic [2:0] b_clr;
        logic [7:0] expected;
        e0 = errors;
        c0 = checks;
        k     = $random(seed);
        a     = $random(seed);
        b_set = $random(seed);
        b_clr = $random(seed);
        in0   = a;
        prog.push_back(lit_instr(2'd0, k));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT0_ADDR));
        prog.push_back(bit_instr(2'd1, b_set, OUT0_ADDR));
        prog.push_back(bit_instr(2'd0, b_clr, OUT0_ADDR));
        prog.push_back(byte_instr(OP_MOVF, 1'b0, IN0_ADDR));
        prog.push_back(byte_instr(OP_MOVWF, 1'b1, OUT1_ADDR));
        add_halt();
        load_program();
        expected = k | (8'h01 << b_set);
        expected = expected & ~(8'h01 << b_clr);  // BCF comes last
        run_for(7);
        compare("BSF and BCF on out0", expected, out0);
        compare("in0 copy on out1", a, out1);
        wb_write(CTRL_ADDR, 12'h000);
        compare("out0 while stopped", 8'h00, out0);
        compare("out1 while stopped", 8'h00, out1);
        run_for(7);
        compare("out0 after restart", expected, out0);
        compare("out1 after restart", a, out1);
        report_test("bits_restart", e0, c0);
    endtask

    initial
    begin
        seed     = 90981;
        errors   = 0;
        checks   = 0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        in0      = '0;
        in1      = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_control_reg();
        test_logic();
        test_arith();
        test_skips();
        test_calls();
        test_bits_restart();
        sva_failures = i_risc_top.i_risc_top_sva.failures;
        $display("Checks passed: %0d, checks failed: %0d, assertion failures: %0d",
                 checks - errors, errors, sva_failures);
        if (errors == 0 && sva_failures == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== sources.f ====
source/risc_pkg.sv
source/host_ctrl.sv
source/program_ram.sv
source/pc_stack.sv
source/instr_decode.sv
source/alu.sv
source/file_regs.sv
source/risc_top.sv
dv/risc_top_sva.sv
dv/tb_risc_top.sv
